/* compile.f */
+incdir+src
src/regfile_pkg.sv
src/regfile_stage_if.sv
src/regfile_bank.sv
src/regfile_init_seq.sv
src/regfile_write_arbiter.sv
src/regfile_read_port.sv
src/regfile.sv
sim/regfile_checker.sv
sim/regfile_tb.sv

/* Makefile */
# Verilator build for the banked register file
VERILATOR ?= verilator
TOP       ?= regfile_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@if grep -q "test failed" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "test passed" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/regfile_tb.sv */
/*
  Testbench for the banked register file.
  Inputs change on rising edges only; regfile_checker does all comparing.
  Random traffic stays on addresses 0 to 7 so that bypass and collision
  cases come up often.
*/
`default_nettype none

`include "regfile_cfg.svh"

module regfile_tb;

  localparam int CLK_PERIOD    = 4;
  localparam int RESET_CYCLES  = 3;
  localparam int INIT_CYCLES   = `RF_BANK_ROWS + 1;
  localparam int RANDOM_CYCLES = 300;
  // init_zero, write_then_read, bypass, collision, const_override, random, drain
  localparam int TEST_CYCLES   = 16 + 36 + 32 + 32 + 16 + RANDOM_CYCLES + 3;
  localparam int WATCHDOG_TIME =
    (RESET_CYCLES + INIT_CYCLES + TEST_CYCLES) * CLK_PERIOD * 2;

  localparam logic [7:0] T_DRAIN      = 8'd0;
  localparam logic [7:0] T_INIT_ZERO  = 8'd1;
  localparam logic [7:0] T_WRITE_READ = 8'd2;
  localparam logic [7:0] T_BYPASS     = 8'd3;
  localparam logic [7:0] T_COLLISION  = 8'd4;
  localparam logic [7:0] T_CONST      = 8'd5;
  localparam logic [7:0] T_RANDOM     = 8'd6;

  logic                   clk = 1'b0;
  logic                   rst;
  logic                   rd0_en;
  logic                   rd1_en;
  logic                   rd0_const_en;
  logic                   rd1_const_en;
  logic                   wr0_en;
  logic                   wr1_en;
  regfile_pkg::reg_addr_t rd0_addr;
  regfile_pkg::reg_addr_t rd1_addr;
  regfile_pkg::reg_addr_t wr0_addr;
  regfile_pkg::reg_addr_t wr1_addr;
  regfile_pkg::reg_data_t rd0_const;
  regfile_pkg::reg_data_t rd1_const;
  regfile_pkg::reg_data_t wr0_data;
  regfile_pkg::reg_data_t wr1_data;
  regfile_pkg::reg_data_t rd0_data;
  regfile_pkg::reg_data_t rd1_data;
  logic                   init_done;
  logic [7:0]             test_id;
  int                     error_count;
  int                     check_count;
  int                     init_errors;

  always #(CLK_PERIOD / 2) clk = ~clk;

  regfile regfile_inst (.*);

  regfile_checker checker_inst (.*);

  // each cycle starts with all strobes low
  task automatic advance_cycle(input logic [7:0] id);
    @(posedge clk);
    rd0_en       <= 1'b0;
    rd1_en       <= 1'b0;
    rd0_const_en <= 1'b0;
    rd1_const_en <= 1'b0;
    wr0_en       <= 1'b0;
    wr1_en       <= 1'b0;
    test_id      <= id;
  endtask

  task automatic drive_read(input int p, input regfile_pkg::reg_addr_t addr,
      input logic cen, input regfile_pkg::reg_data_t cval);
    if (p == 0) begin
      rd0_en       <= 1'b1;
      rd0_addr     <= addr;
      rd0_const_en <= cen;
      rd0_const    <= cval;
    end else begin
      rd1_en       <= 1'b1;
      rd1_addr     <= addr;
      rd1_const_en <= cen;
      rd1_const    <= cval;
    end
  endtask

  task automatic drive_write(input int p, input regfile_pkg::reg_addr_t addr,
      input regfile_pkg::reg_data_t data);
    if (p == 0) begin
      wr0_en   <= 1'b1;
      wr0_addr <= addr;
      wr0_data <= data;
    end else begin
      wr1_en   <= 1'b1;
      wr1_addr <= addr;
      wr1_data <= data;
    end
  endtask

  function automatic regfile_pkg::reg_addr_t random_addr(input int span);
    return regfile_pkg::reg_addr_t'($urandom % span);
  endfunction

  // zeroing takes one edge per bank row with rst low
  task automatic wait_init_done();
    do begin
      @(posedge clk);
    end while (init_done !== 1'b1);
  endtask

  task automatic read_all_registers();
    for (int i = 0; i < `RF_BANK_ROWS; i++) begin
      advance_cycle(T_INIT_ZERO);
      drive_read(0, regfile_pkg::reg_addr_t'(2 * i), 1'b0, '0);
      drive_read(1, regfile_pkg::reg_addr_t'(2 * i + 1), 1'b0, '0);
    end
  endtask

  task automatic write_then_read();
    regfile_pkg::reg_addr_t addrs [16];
    for (int i = 0; i < 16; i++) begin
      advance_cycle(T_WRITE_READ);
      addrs[i] = random_addr(32);
      drive_write(i % 2, addrs[i], $urandom);
    end
    repeat (4) advance_cycle(T_WRITE_READ);
    for (int i = 0; i < 16; i++) begin
      advance_cycle(T_WRITE_READ);
      drive_read(i % 2, addrs[i], 1'b0, '0);
    end
  endtask

  // reads at N, N+1 and N+2 against a write in cycle N
  task automatic bypass_reads();
    regfile_pkg::reg_addr_t a;
    for (int k = 0; k < 8; k++) begin
      a = random_addr(32);
      advance_cycle(T_BYPASS);
      drive_write(k % 2, a, $urandom);
      drive_read(0, a, 1'b0, '0);
      advance_cycle(T_BYPASS);
      drive_read(1, a, 1'b0, '0);
      advance_cycle(T_BYPASS);
      drive_read(0, a, 1'b0, '0);
      advance_cycle(T_BYPASS);
    end
  endtask

  task automatic colliding_writes();
    regfile_pkg::reg_addr_t a;
    regfile_pkg::reg_data_t d;
    for (int k = 0; k < 8; k++) begin
      a = random_addr(32);
      d = $urandom;
      advance_cycle(T_COLLISION);
      drive_write(0, a, d);
      drive_write(1, a, ~d);
      advance_cycle(T_COLLISION);
      drive_read(0, a, 1'b0, '0);
      advance_cycle(T_COLLISION);
      advance_cycle(T_COLLISION);
      drive_read(1, a, 1'b0, '0);
    end
  endtask

  task automatic const_reads();
    regfile_pkg::reg_addr_t a;
    for (int k = 0; k < 8; k++) begin
      a = random_addr(32);
      advance_cycle(T_CONST);
      drive_write(0, a, $urandom);
      drive_read(0, a, 1'b1, $urandom);
      drive_read(1, a, 1'b1, $urandom);
      advance_cycle(T_CONST);
    end
  endtask

  task automatic random_traffic();
    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      advance_cycle(T_RANDOM);
      for (int p = 0; p < 2; p++) begin
        if ($urandom % 2 == 1) begin
          drive_read(p, random_addr(8), ($urandom % 4 == 0), $urandom);
        end
        if ($urandom % 2 == 1) begin
          drive_write(p, random_addr(8), $urandom);
        end
      end
    end
  endtask

  initial begin
    void'($urandom(98));
    rst          = 1'b1;
    rd0_en       = 1'b0;
    rd1_en       = 1'b0;
    rd0_const_en = 1'b0;
    rd1_const_en = 1'b0;
    rd0_addr     = '0;
    rd1_addr     = '0;
    rd0_const    = '0;
    rd1_const    = '0;
    wr0_en       = 1'b0;
    wr1_en       = 1'b0;
    wr0_addr     = '0;
    wr1_addr     = '0;
    wr0_data     = '0;
    wr1_data     = '0;
    test_id      = T_DRAIN;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    wait_init_done();
    read_all_registers();
    write_then_read();
    bypass_reads();
    colliding_writes();
    const_reads();
    random_traffic();
    repeat (3) advance_cycle(T_DRAIN);
    $display("checks %0d, read mismatches %0d, init errors %0d",
             check_count, error_count, init_errors);
    if (error_count == 0 && init_errors == 0 && check_count > 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("watchdog expired after %0d time units, tests did not finish", WATCHDOG_TIME);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/regfile_checker.sv */
/*
  Scoreboard for the register file top level.
  Models the staged writes and the banks on its own and compares rd_data
  every cycle once a port has made a request. Reads issued before
  init_done are not tracked. init_done is checked on every edge after
  reset release. Counters are never cleared.
*/
`default_nettype none

`include "regfile_cfg.svh"

module regfile_checker (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic [7:0]             test_id,
  input  wire logic                   rd0_en,
  input  wire regfile_pkg::reg_addr_t rd0_addr,
  input  wire logic                   rd0_const_en,
  input  wire regfile_pkg::reg_data_t rd0_const,
  input  wire regfile_pkg::reg_data_t rd0_data,
  input  wire logic                   rd1_en,
  input  wire regfile_pkg::reg_addr_t rd1_addr,
  input  wire logic                   rd1_const_en,
  input  wire regfile_pkg::reg_data_t rd1_const,
  input  wire regfile_pkg::reg_data_t rd1_data,
  input  wire logic                   wr0_en,
  input  wire regfile_pkg::reg_addr_t wr0_addr,
  input  wire regfile_pkg::reg_data_t wr0_data,
  input  wire logic                   wr1_en,
  input  wire regfile_pkg::reg_addr_t wr1_addr,
  input  wire regfile_pkg::reg_data_t wr1_data,
  input  wire logic                   init_done,
  output int                          error_count,
  output int                          check_count,
  output int                          init_errors
);

  regfile_pkg::reg_data_t bank_model [`RF_REG_COUNT];
  logic [1:0]             stg_en;
  regfile_pkg::reg_addr_t stg_addr [2];
  regfile_pkg::reg_data_t stg_data [2];
  logic [1:0]             req_valid;
  regfile_pkg::reg_addr_t req_addr [2];
  logic [1:0]             req_const_en;
  regfile_pkg::reg_data_t req_const [2];
  logic [7:0]             req_test [2];
  regfile_pkg::reg_data_t rd_data_w [2];
  int                     release_edges;

  assign rd_data_w[0] = rd0_data;
  assign rd_data_w[1] = rd1_data;

  function automatic string test_label(input logic [7:0] id);
    case (id)
      8'd1:    return "init_zero";
      8'd2:    return "write_then_read";
      8'd3:    return "bypass";
      8'd4:    return "collision";
      8'd5:    return "const_override";
      8'd6:    return "random_traffic";
      default: return "drain";
    endcase
  endfunction

  // constant first, then the newer staged write, then the bank
  function automatic regfile_pkg::reg_data_t expected_read(input logic cen,
      input regfile_pkg::reg_data_t cval, input regfile_pkg::reg_addr_t addr);
    if (cen) begin
      return cval;
    end
    if (stg_en[1] && (stg_addr[1] == addr)) begin
      return stg_data[1];
    end
    if (stg_en[0] && (stg_addr[0] == addr)) begin
      return stg_data[0];
    end
    return bank_model[addr];
  endfunction

  task automatic register_request(input int p, input logic en,
      input regfile_pkg::reg_addr_t addr, input logic cen,
      input regfile_pkg::reg_data_t cval);
    if (en && init_done) begin
      req_valid[p]    = 1'b1;
      req_addr[p]     = addr;
      req_const_en[p] = cen;
      req_const[p]    = cval;
      req_test[p]     = test_id;
    end
  endtask

  always @(posedge clk) begin
    regfile_pkg::reg_data_t want;
    logic                   init_want;
    if (rst) begin
      // zeroing leaves every register at zero
      for (int i = 0; i < `RF_REG_COUNT; i++) begin
        bank_model[i] = '0;
      end
      stg_en        = '0;
      req_valid     = '0;
      release_edges = 0;
    end else begin
      // one bank row is zeroed per edge after reset release
      release_edges++;
      init_want = (release_edges > `RF_BANK_ROWS);
      if (init_done !== init_want) begin
        init_errors++;
        $display("init_done was %b %0d edges after reset release, expected %b",
                 init_done, release_edges, init_want);
      end
      for (int p = 0; p < 2; p++) begin
        if (req_valid[p]) begin
          check_count++;
          want = expected_read(req_const_en[p], req_const[p], req_addr[p]);
          if (rd_data_w[p] !== want) begin
            error_count++;
            $display("CHECK FAILED %s: port %0d addr %0d expected %h actual %h",
                     test_label(req_test[p]), p, req_addr[p], want, rd_data_w[p]);
          end
        end
      end
      // last cycle's staged writes land in the banks with port 1 applied last
      for (int p = 0; p < 2; p++) begin
        if (stg_en[p]) begin
          bank_model[stg_addr[p]] = stg_data[p];
        end
      end
      stg_en[0]   = wr0_en && init_done && !(wr1_en && (wr1_addr == wr0_addr));
      stg_en[1]   = wr1_en && init_done;
      stg_addr[0] = wr0_addr;
      stg_addr[1] = wr1_addr;
      stg_data[0] = wr0_data;
      stg_data[1] = wr1_data;
      register_request(0, rd0_en, rd0_addr, rd0_const_en, rd0_const);
      register_request(1, rd1_en, rd1_addr, rd1_const_en, rd1_const);
    end
  end

endmodule

`default_nettype wire

/* src/regfile.sv */
/*
  Banked write-first register file, two read and two write ports.
  Read data arrives one cycle after rd_en. Writes are ignored until
  init_done rises, which takes RF_BANK_ROWS cycles of zeroing after reset.
*/
`default_nettype none

`include "regfile_cfg.svh"

module regfile (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              rd0_en,
  input  regfile_pkg::reg_addr_t rd0_addr,
  input  wire logic              rd0_const_en,
  input  regfile_pkg::reg_data_t rd0_const,
  output regfile_pkg::reg_data_t rd0_data,
  input  wire logic              rd1_en,
  input  regfile_pkg::reg_addr_t rd1_addr,
  input  wire logic              rd1_const_en,
  input  regfile_pkg::reg_data_t rd1_const,
  output regfile_pkg::reg_data_t rd1_data,
  input  wire logic              wr0_en,
  input  regfile_pkg::reg_addr_t wr0_addr,
  input  regfile_pkg::reg_data_t wr0_data,
  input  wire logic              wr1_en,
  input  regfile_pkg::reg_addr_t wr1_addr,
  input  regfile_pkg::reg_data_t wr1_data,
  output logic                   init_done
);

  logic                   init_active;
  regfile_pkg::bank_row_t init_row;

  logic [`RF_PORTS-1:0]   wr_en;
  regfile_pkg::reg_addr_t wr_addr [`RF_PORTS];
  regfile_pkg::reg_data_t wr_data [`RF_PORTS];

  logic [`RF_PORTS-1:0]   rd_en;
  regfile_pkg::reg_addr_t rd_addr [`RF_PORTS];
  logic [`RF_PORTS-1:0]   rd_const_en;
  regfile_pkg::reg_data_t rd_const [`RF_PORTS];
  regfile_pkg::reg_data_t rd_data [`RF_PORTS];

  logic [`RF_PORTS-1:0]   bank0_wr_en;
  logic [`RF_PORTS-1:0]   bank1_wr_en;
  regfile_pkg::bank_row_t bank0_wr_row [`RF_PORTS];
  regfile_pkg::bank_row_t bank1_wr_row [`RF_PORTS];
  regfile_pkg::reg_data_t bank0_wr_data [`RF_PORTS];
  regfile_pkg::reg_data_t bank1_wr_data [`RF_PORTS];

  logic [1:0]             port_bank_rd_en [`RF_PORTS];
  logic [`RF_PORTS-1:0]   bank0_rd_en;
  logic [`RF_PORTS-1:0]   bank1_rd_en;
  regfile_pkg::bank_row_t bank_rd_row [`RF_PORTS];
  regfile_pkg::reg_data_t bank0_rd_data [`RF_PORTS];
  regfile_pkg::reg_data_t bank1_rd_data [`RF_PORTS];

  assign wr_en       = {wr1_en, wr0_en};
  assign wr_addr[0]  = wr0_addr;
  assign wr_addr[1]  = wr1_addr;
  assign wr_data[0]  = wr0_data;
  assign wr_data[1]  = wr1_data;

  assign rd_en       = {rd1_en, rd0_en};
  assign rd_const_en = {rd1_const_en, rd0_const_en};
  assign rd_addr[0]  = rd0_addr;
  assign rd_addr[1]  = rd1_addr;
  assign rd_const[0] = rd0_const;
  assign rd_const[1] = rd1_const;
  assign rd0_data    = rd_data[0];
  assign rd1_data    = rd_data[1];

  assign init_done = !init_active;

  regfile_stage_if stage_bus ();

  regfile_init_seq init_seq_inst (
    .clk         (clk),
    .rst         (rst),
    .init_active (init_active),
    .init_row    (init_row)
  );

  regfile_write_arbiter write_arbiter_inst (
    .clk           (clk),
    .rst           (rst),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .init_active   (init_active),
    .init_row      (init_row),
    .stage         (stage_bus.arbiter),
    .bank0_wr_en   (bank0_wr_en),
    .bank1_wr_en   (bank1_wr_en),
    .bank0_wr_row  (bank0_wr_row),
    .bank1_wr_row  (bank1_wr_row),
    .bank0_wr_data (bank0_wr_data),
    .bank1_wr_data (bank1_wr_data)
  );

  for (genvar p = 0; p < `RF_PORTS; p++) begin : g_read
    assign bank0_rd_en[p] = port_bank_rd_en[p][0];
    assign bank1_rd_en[p] = port_bank_rd_en[p][1];

    regfile_read_port read_port_inst (
      .clk         (clk),
      .rst         (rst),
      .rd_en       (rd_en[p]),
      .rd_addr     (rd_addr[p]),
      .const_en    (rd_const_en[p]),
      .const_val   (rd_const[p]),
      .stage       (stage_bus.reader),
      .bank_rd_en  (port_bank_rd_en[p]),
      .bank_rd_row (bank_rd_row[p]),
      .bank0_data  (bank0_rd_data[p]),
      .bank1_data  (bank1_rd_data[p]),
      .rd_data     (rd_data[p])
    );
  end

  // even addresses
  regfile_bank bank0_inst (
    .clk     (clk),
    .wr_en   (bank0_wr_en),
    .wr_row  (bank0_wr_row),
    .wr_data (bank0_wr_data),
    .rd_en   (bank0_rd_en),
    .rd_row  (bank_rd_row),
    .rd_data (bank0_rd_data)
  );

  // odd addresses
  regfile_bank bank1_inst (
    .clk     (clk),
    .wr_en   (bank1_wr_en),
    .wr_row  (bank1_wr_row),
    .wr_data (bank1_wr_data),
    .rd_en   (bank1_rd_en),
    .rd_row  (bank_rd_row),
    .rd_data (bank1_rd_data)
  );

endmodule

`default_nettype wire

/* src/regfile_read_port.sv */
/*
  One read port with write-first bypass.
  The request is captured on rd_en; the result in the next cycle is the
  constant, else the matching staged write (slot 1 first), else bank data.
  With rd_en low the captured request holds and rd_data keeps tracking it.
*/
`default_nettype none

`include "regfile_cfg.svh"

module regfile_read_port (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              rd_en,
  input  regfile_pkg::reg_addr_t rd_addr,
  input  wire logic              const_en,
  input  regfile_pkg::reg_data_t const_val,
  regfile_stage_if.reader        stage,
  output logic [1:0]             bank_rd_en,
  output regfile_pkg::bank_row_t bank_rd_row,
  input  regfile_pkg::reg_data_t bank0_data,
  input  regfile_pkg::reg_data_t bank1_data,
  output regfile_pkg::reg_data_t rd_data
);

  regfile_pkg::reg_addr_t addr_q;
  logic                   const_en_q;
  regfile_pkg::reg_data_t const_q;
  logic [`RF_PORTS-1:0]   match;
  regfile_pkg::read_src_t src;
  regfile_pkg::reg_data_t bank_data;

  // only the bank holding the address captures the row
  assign bank_rd_en[0] = rd_en && !rd_addr[0];
  assign bank_rd_en[1] = rd_en && rd_addr[0];
  assign bank_rd_row   = rd_addr[`RF_ADDR_WIDTH-1:1];

  always_ff @(posedge clk) begin
    if (rst) begin
      addr_q     <= '0;
      const_en_q <= 1'b0;
    end else if (rd_en) begin
      addr_q     <= rd_addr;
      const_en_q <= const_en;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      const_q <= const_val;
    end
  end

  always_comb begin
    for (int p = 0; p < `RF_PORTS; p++) begin
      match[p] = stage.stage_en[p] && (stage.stage_addr[p] == addr_q);
    end
  end

  always_comb begin
    if (const_en_q) begin
      src = regfile_pkg::src_const;
    end else if (match[1]) begin
      src = regfile_pkg::src_stage1;
    end else if (match[0]) begin
      src = regfile_pkg::src_stage0;
    end else begin
      src = regfile_pkg::src_bank;
    end
  end

  assign bank_data = addr_q[0] ? bank1_data : bank0_data;

  always_comb begin
    case (src)
      regfile_pkg::src_const:  rd_data = const_q;
      regfile_pkg::src_stage1: rd_data = stage.stage_data[1];
      regfile_pkg::src_stage0: rd_data = stage.stage_data[0];
      default:                 rd_data = bank_data;
    endcase
  end

  // the arbiter never stages one address in both slots
  single_stage_match: assert property (@(posedge clk) disable iff (rst)
    !(&match));

endmodule

`default_nettype wire

/* src/regfile_write_arbiter.sv */
/*
  Write staging and bank write grant.
  All writes are dropped while init_active is high. On a same-address
  collision port 1 wins. Staged writes go to the bank chosen by address bit 0.
  During zeroing only write port 0 of each bank is used.
*/
`default_nettype none

`include "regfile_cfg.svh"

module regfile_write_arbiter (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic [`RF_PORTS-1:0] wr_en,
  input  regfile_pkg::reg_addr_t    wr_addr [`RF_PORTS],
  input  regfile_pkg::reg_data_t    wr_data [`RF_PORTS],
  input  wire logic                 init_active,
  input  regfile_pkg::bank_row_t    init_row,
  regfile_stage_if.arbiter          stage,
  output logic [`RF_PORTS-1:0]      bank0_wr_en,
  output logic [`RF_PORTS-1:0]      bank1_wr_en,
  output regfile_pkg::bank_row_t    bank0_wr_row [`RF_PORTS],
  output regfile_pkg::bank_row_t    bank1_wr_row [`RF_PORTS],
  output regfile_pkg::reg_data_t    bank0_wr_data [`RF_PORTS],
  output regfile_pkg::reg_data_t    bank1_wr_data [`RF_PORTS]
);

  logic collide;

  assign collide = wr_en[0] && wr_en[1] && (wr_addr[0] == wr_addr[1]);

  always_ff @(posedge clk) begin
    if (rst) begin
      stage.stage_en <= '0;
    end else begin
      stage.stage_en[0] <= wr_en[0] && !init_active && !collide;
      stage.stage_en[1] <= wr_en[1] && !init_active;
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < `RF_PORTS; p++) begin
      if (wr_en[p]) begin
        stage.stage_addr[p] <= wr_addr[p];
        stage.stage_data[p] <= wr_data[p];
      end
    end
  end

  always_comb begin
    for (int p = 0; p < `RF_PORTS; p++) begin
      if (init_active) begin
        // zeroing holds off while reset is still asserted
        bank0_wr_en[p]   = (p == 0) && !rst;
        bank1_wr_en[p]   = (p == 0) && !rst;
        bank0_wr_row[p]  = init_row;
        bank1_wr_row[p]  = init_row;
        bank0_wr_data[p] = '0;
        bank1_wr_data[p] = '0;
      end else begin
        bank0_wr_en[p]   = stage.stage_en[p] && !stage.stage_addr[p][0];
        bank1_wr_en[p]   = stage.stage_en[p] && stage.stage_addr[p][0];
        bank0_wr_row[p]  = stage.stage_addr[p][`RF_ADDR_WIDTH-1:1];
        bank1_wr_row[p]  = stage.stage_addr[p][`RF_ADDR_WIDTH-1:1];
        bank0_wr_data[p] = stage.stage_data[p];
        bank1_wr_data[p] = stage.stage_data[p];
      end
    end
  end

  stage_addr_distinct: assert property (@(posedge clk) disable iff (rst)
    (&stage.stage_en) |-> (stage.stage_addr[0] != stage.stage_addr[1]));

endmodule

`default_nettype wire

/* src/regfile_init_seq.sv */
/*
  Post-reset zeroing sequencer.
  Walks bank rows 0 to RF_BANK_ROWS-1, one row per cycle, then idles
  until the next reset. init_active is high from reset through the last row.
*/
`default_nettype none

`include "regfile_cfg.svh"

module regfile_init_seq (
  input  wire logic              clk,
  input  wire logic              rst,
  output logic                   init_active,
  output regfile_pkg::bank_row_t init_row
);

  regfile_pkg::init_state_t state;
  regfile_pkg::bank_row_t   row;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= regfile_pkg::init_zeroing;
      row   <= '0;
    end else if (state == regfile_pkg::init_zeroing) begin
      row <= row + 1'b1;
      if (row == regfile_pkg::bank_row_t'(`RF_BANK_ROWS - 1)) begin
        state <= regfile_pkg::init_idle;
      end
    end
  end

  assign init_active = (state == regfile_pkg::init_zeroing);
  assign init_row    = row;

  // idle is terminal until reset
  idle_sticky: assert property (@(posedge clk) disable iff (rst)
    (state == regfile_pkg::init_idle) |=> (state == regfile_pkg::init_idle));

endmodule

`default_nettype wire

/* src/regfile_bank.sv */
/*
  One register bank, two write ports and two reads.
  Read rows are captured on rd_en and the array is read combinationally
  from the captured row, so read data follows writes to that row.
  Write port 1 is applied after port 0; the two never share a row.
*/
`default_nettype none

`include "regfile_cfg.svh"

module regfile_bank (
  input  wire logic                   clk,
  input  wire logic [`RF_PORTS-1:0]   wr_en,
  input  regfile_pkg::bank_row_t      wr_row [`RF_PORTS],
  input  regfile_pkg::reg_data_t      wr_data [`RF_PORTS],
  input  wire logic [`RF_PORTS-1:0]   rd_en,
  input  regfile_pkg::bank_row_t      rd_row [`RF_PORTS],
  output regfile_pkg::reg_data_t      rd_data [`RF_PORTS]
);

  regfile_pkg::reg_data_t mem [`RF_BANK_ROWS];
  regfile_pkg::bank_row_t rd_row_q [`RF_PORTS];

  always_ff @(posedge clk) begin
    for (int p = 0; p < `RF_PORTS; p++) begin
      if (rd_en[p]) begin
        rd_row_q[p] <= rd_row[p];
      end
    end
    for (int p = 0; p < `RF_PORTS; p++) begin
      if (wr_en[p]) begin
        mem[wr_row[p]] <= wr_data[p];
      end
    end
  end

  always_comb begin
    for (int p = 0; p < `RF_PORTS; p++) begin
      rd_data[p] = mem[rd_row_q[p]];
    end
  end

  // the arbiter must never hand both ports the same row
  wr_row_distinct: assert property (@(posedge clk)
    (&wr_en) |-> (wr_row[0] != wr_row[1]));

endmodule

`default_nettype wire

/* src/regfile_stage_if.sv */
/*
  Staged writes, one slot per write port.
  A slot is valid for exactly one cycle, the cycle before its bank write.
  The two valid slots never carry the same address.
*/
`default_nettype none

`include "regfile_cfg.svh"

interface regfile_stage_if;

  logic [`RF_PORTS-1:0]  stage_en;
  regfile_pkg::reg_addr_t stage_addr [`RF_PORTS];
  regfile_pkg::reg_data_t stage_data [`RF_PORTS];

  modport arbiter (
    output stage_en,
    output stage_addr,
    output stage_data
  );

  modport reader (
    input stage_en,
    input stage_addr,
    input stage_data
  );

endinterface

`default_nettype wire

/* src/regfile_pkg.sv */
/*
  Shared types of the register file.
  A bank row is the register address without its lowest bit.
*/
`default_nettype none

`include "regfile_cfg.svh"

package regfile_pkg;

  typedef logic [`RF_ADDR_WIDTH-1:0] reg_addr_t;
  typedef logic [`RF_DATA_WIDTH-1:0] reg_data_t;
  typedef logic [`RF_ADDR_WIDTH-2:0] bank_row_t;

  typedef enum logic {
    init_zeroing,
    init_idle
  } init_state_t;

  // where a read result comes from
  typedef enum logic [1:0] {
    src_bank,
    src_stage0,
    src_stage1,
    src_const
  } read_src_t;

endpackage

`default_nettype wire

/* src/regfile_cfg.svh */
/*
  Sizes of the banked register file.
  The bank count is fixed at two and is chosen by the lowest address bit,
  so RF_BANK_ROWS must stay RF_REG_COUNT / 2 and RF_ADDR_WIDTH must cover it.
  RF_PORTS sets both the read and the write port count.
*/
`ifndef REGFILE_CFG_SVH
`define REGFILE_CFG_SVH

`define RF_DATA_WIDTH 32
`define RF_REG_COUNT 32
`define RF_ADDR_WIDTH 5

// two banks split on address bit 0
`define RF_BANK_ROWS (`RF_REG_COUNT / 2)

`define RF_PORTS 2

`endif
